/* build.f */
logic/softreg_pkg.sv
logic/shell_pkg.sv
logic/axil_softreg_bridge.sv
logic/softreg_pipe.sv
logic/softreg_router.sv
logic/app_regfile.sv
logic/aos_shell_top.sv
sim/tb_aos_shell.sv

/* logic/aos_shell_top.sv */
// Shell top level joining the host bridge, SoftReg pipes, router and app blocks
`timescale 1ns/100ps

module aos_shell_top #(
	parameter int NUM_APPS    = 4,
	parameter int HOST_STAGES = 2,
	parameter int APP_STAGES  = 2
) (
	input  logic                 global_clk,
	input  logic                 reset,
	input  logic [NUM_APPS-1:0]  app_enable,
	input  shell_pkg::axil_in_t  host,
	output shell_pkg::axil_out_t host_rsp
);
	import softreg_pkg::*;

	sr_req_t  bridge_req;
	sr_resp_t bridge_resp;
	sr_req_t  router_req;
	sr_resp_t router_resp;
	sr_req_t  route_req  [NUM_APPS];
	sr_resp_t route_resp [NUM_APPS];

	// ----------------------------------------
	// Host side
	// ----------------------------------------
	axil_softreg_bridge bridge (
		.global_clk (global_clk),
		.reset      (reset),
		.host       (host),
		.host_rsp   (host_rsp),
		.sr_req     (bridge_req),
		.sr_resp    (bridge_resp)
	);

	softreg_pipe #(.STAGES(HOST_STAGES)) host_pipe (
		.global_clk (global_clk),
		.reset      (reset),
		.req_in     (bridge_req),
		.req_out    (router_req),
		.resp_in    (router_resp),
		.resp_out   (bridge_resp)
	);

	softreg_router #(.NUM_APPS(NUM_APPS)) router (
		.global_clk (global_clk),
		.reset      (reset),
		.app_enable (app_enable),
		.host_req   (router_req),
		.host_resp  (router_resp),
		.app_req    (route_req),
		.app_resp   (route_resp)
	);

	// ----------------------------------------
	// Application slots
	// ----------------------------------------
	genvar a;
	generate
		for (a = 0; a < NUM_APPS; a++) begin : app
			sr_req_t  app_req;
			sr_resp_t app_resp;

			softreg_pipe #(.STAGES(APP_STAGES)) app_pipe (
				.global_clk (global_clk),
				.reset      (reset),
				.req_in     (route_req[a]),
				.req_out    (app_req),
				.resp_in    (app_resp),
				.resp_out   (route_resp[a])
			);

			app_regfile #(.APP_INDEX(a)) regs (
				.global_clk (global_clk),
				.reset      (reset),
				.sr_req     (app_req),
				.sr_resp    (app_resp)
			);
		end
	endgenerate

endmodule

/* logic/app_regfile.sv */
// Per-application SoftReg register block with a read-only signature register
`timescale 1ns/100ps

module app_regfile #(
	parameter int APP_INDEX = 0
) (
	input  logic                  global_clk,
	input  logic                  reset,
	input  softreg_pkg::sr_req_t  sr_req,
	output softreg_pkg::sr_resp_t sr_resp
);
	import softreg_pkg::*;

	localparam int NUM_REGS = 2 ** REG_OFS_BITS;

	// Register 0 is the signature, so storage starts at 1
	sr_data_t                regs [1:NUM_REGS-1];
	logic [REG_OFS_BITS-1:0] ofs;
	sr_data_t                rd_data;

	assign ofs = sr_req.addr.fields.ofs;

	always_comb begin
		if (ofs == '0)
			rd_data = {APP_SIGNATURE, 32'(APP_INDEX)};
		else
			rd_data = regs[ofs];
	end

	always_ff @(posedge global_clk) begin
		sr_resp.data <= rd_data;
		if (reset) begin
			for (int r = 1; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
			sr_resp.valid <= 1'b0;
		end else begin
			// Reads answer, writes stay silent
			sr_resp.valid <= sr_req.valid && !sr_req.is_write;
			if (sr_req.valid && sr_req.is_write && ofs != '0)
				regs[ofs] <= sr_req.data;
		end
	end

endmodule

/* logic/axil_softreg_bridge.sv */
// AXI-Lite slave FSM that turns 32-bit host accesses into 64-bit SoftReg requests
`timescale 1ns/100ps

module axil_softreg_bridge (
	input  logic                  global_clk,
	input  logic                  reset,
	input  shell_pkg::axil_in_t   host,
	output shell_pkg::axil_out_t  host_rsp,
	output softreg_pkg::sr_req_t  sr_req,
	input  softreg_pkg::sr_resp_t sr_resp
);
	import shell_pkg::*;
	import softreg_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR_RESP,
		ST_RD_WAIT,
		ST_RD_RESP
	} state_t;

	state_t     state;
	logic       idle;
	logic       wr_go;
	logic       rd_go;
	axil_data_t wr_low;
	axil_data_t hi_cache;
	axil_data_t rd_data;

	// 64-bit word index from a byte address
	function automatic sr_addr_u word_addr(input logic [AXIL_ADDR_BITS-1:0] byte_addr);
		sr_addr_u a;
		a.raw = SR_ADDR_BITS'(byte_addr >> 3);
		return a;
	endfunction

	assign idle  = (state == ST_IDLE);
	assign wr_go = idle && host.awvalid && host.wvalid;
	// Writes win when both arrive together
	assign rd_go = idle && host.arvalid && !(host.awvalid && host.wvalid);

	always_comb begin
		host_rsp.awready = idle;
		host_rsp.wready  = idle;
		host_rsp.arready = idle && !(host.awvalid && host.wvalid);
		host_rsp.bvalid  = (state == ST_WR_RESP);
		host_rsp.bresp   = AXIL_OKAY;
		host_rsp.rvalid  = (state == ST_RD_RESP);
		host_rsp.rdata   = rd_data;
		host_rsp.rresp   = AXIL_OKAY;
	end

	// ----------------------------------------
	// Transaction sequencing
	// ----------------------------------------
	always_ff @(posedge global_clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (wr_go)
						state <= ST_WR_RESP;
					else if (rd_go)
						state <= host.araddr[2] ? ST_RD_RESP : ST_RD_WAIT;
				end
				ST_WR_RESP: if (host.bready) state <= ST_IDLE;
				ST_RD_WAIT: if (sr_resp.valid) state <= ST_RD_RESP;
				ST_RD_RESP: if (host.rready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Half-word assembly and SoftReg issue
	// ----------------------------------------
	always_ff @(posedge global_clk) begin
		sr_req.valid <= 1'b0;
		if (wr_go) begin
			if (host.awaddr[2]) begin
				// High half completes the 64-bit word
				sr_req.valid    <= 1'b1;
				sr_req.is_write <= 1'b1;
				sr_req.addr     <= word_addr(host.awaddr);
				sr_req.data     <= {host.wdata, wr_low};
			end else begin
				wr_low <= host.wdata;
			end
		end
		if (rd_go) begin
			if (host.araddr[2]) begin
				rd_data <= hi_cache;
			end else begin
				sr_req.valid    <= 1'b1;
				sr_req.is_write <= 1'b0;
				sr_req.addr     <= word_addr(host.araddr);
			end
		end
		// Low half goes to the host, high half waits for the next read
		if (state == ST_RD_WAIT && sr_resp.valid) begin
			rd_data  <= sr_resp.data[AXIL_DATA_BITS-1:0];
			hi_cache <= sr_resp.data[SR_DATA_BITS-1:AXIL_DATA_BITS];
		end
		if (reset)
			sr_req.valid <= 1'b0;
	end

endmodule

/* logic/shell_pkg.sv */
// AXI-Lite channel bundles and response codes for the host register port
package shell_pkg;

	localparam int AXIL_ADDR_BITS = 32;
	localparam int AXIL_DATA_BITS = 32;

	typedef logic [AXIL_DATA_BITS-1:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t AXIL_OKAY = 2'b00;

	// Everything the host drives
	typedef struct packed {
		logic                        awvalid;
		logic [AXIL_ADDR_BITS-1:0]   awaddr;
		logic                        wvalid;
		axil_data_t                  wdata;
		logic [AXIL_DATA_BITS/8-1:0] wstrb;
		logic                        bready;
		logic                        arvalid;
		logic [AXIL_ADDR_BITS-1:0]   araddr;
		logic                        rready;
	} axil_in_t;

	// Everything the shell drives back
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		axil_resp_t bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_out_t;

endpackage

/* logic/softreg_pipe.sv */
// Register pipeline for SoftReg requests downstream and responses upstream
`timescale 1ns/100ps

module softreg_pipe #(
	parameter int STAGES = 2
) (
	input  logic                  global_clk,
	input  logic                  reset,
	input  softreg_pkg::sr_req_t  req_in,
	output softreg_pkg::sr_req_t  req_out,
	input  softreg_pkg::sr_resp_t resp_in,
	output softreg_pkg::sr_resp_t resp_out
);
	import softreg_pkg::*;

	sr_req_t  req_q  [STAGES];
	sr_resp_t resp_q [STAGES];

	always_ff @(posedge global_clk) begin
		req_q[0]  <= req_in;
		resp_q[0] <= resp_in;
		for (int s = 1; s < STAGES; s++) begin
			req_q[s]  <= req_q[s-1];
			resp_q[s] <= resp_q[s-1];
		end
		// Reset drops everything in flight
		if (reset) begin
			for (int s = 0; s < STAGES; s++) begin
				req_q[s].valid  <= 1'b0;
				resp_q[s].valid <= 1'b0;
			end
		end
	end

	assign req_out  = req_q[STAGES-1];
	assign resp_out = resp_q[STAGES-1];

endmodule

/* logic/softreg_pkg.sv */
// SoftReg request, response and address types and the application register map
package softreg_pkg;

	localparam int SR_DATA_BITS = 64;
	localparam int SR_ADDR_BITS = 32;

	// Application register map
	localparam int APP_IDX_BITS = 2;
	localparam int REG_OFS_BITS = 3;
	localparam int ADDR_PAD_BITS = SR_ADDR_BITS - APP_IDX_BITS - REG_OFS_BITS;

	// Upper half of register 0 in every application
	localparam logic [31:0] APP_SIGNATURE = 32'hA05C_0DE1;

	typedef logic [SR_DATA_BITS-1:0] sr_data_t;

	// Word index as seen by the bridge, app/register pair as seen by the router
	typedef union packed {
		logic [SR_ADDR_BITS-1:0] raw;
		struct packed {
			logic [ADDR_PAD_BITS-1:0] unused;
			logic [APP_IDX_BITS-1:0]  app;
			logic [REG_OFS_BITS-1:0]  ofs;
		} fields;
	} sr_addr_u;

	typedef struct packed {
		logic     valid;
		logic     is_write;
		sr_addr_u addr;
		sr_data_t data;
	} sr_req_t;

	typedef struct packed {
		logic     valid;
		sr_data_t data;
	} sr_resp_t;

endpackage

/* logic/softreg_router.sv */
// SoftReg router with application decode, enable masking and response merge
`timescale 1ns/100ps

module softreg_router #(
	parameter int NUM_APPS = 4
) (
	input  logic                  global_clk,
	input  logic                  reset,
	input  logic [NUM_APPS-1:0]   app_enable,
	input  softreg_pkg::sr_req_t  host_req,
	output softreg_pkg::sr_resp_t host_resp,
	output softreg_pkg::sr_req_t  app_req [NUM_APPS],
	input  softreg_pkg::sr_resp_t app_resp [NUM_APPS]
);
	import softreg_pkg::*;

	logic [NUM_APPS-1:0] hit;
	logic                app_on;
	logic                miss_rd;
	logic                merge_valid;
	sr_data_t            merge_data;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	always_comb begin
		for (int a = 0; a < NUM_APPS; a++) begin
			hit[a] = (host_req.addr.fields.app == APP_IDX_BITS'(a));
		end
	end

	// App indices past NUM_APPS count as disabled
	assign app_on  = |(hit & app_enable);
	assign miss_rd = host_req.valid && !host_req.is_write && !app_on;

	// ----------------------------------------
	// Response merge
	// ----------------------------------------
	always_comb begin
		merge_valid = 1'b0;
		merge_data  = '0;
		for (int a = 0; a < NUM_APPS; a++) begin
			if (app_resp[a].valid) begin
				merge_valid = 1'b1;
				merge_data  = merge_data | app_resp[a].data;
			end
		end
		// Disabled app reads back as all ones
		if (miss_rd) begin
			merge_valid = 1'b1;
			merge_data  = '1;
		end
	end

	always_ff @(posedge global_clk) begin
		for (int a = 0; a < NUM_APPS; a++) begin
			app_req[a]       <= host_req;
			app_req[a].valid <= host_req.valid && hit[a] && app_enable[a];
		end
		host_resp.valid <= merge_valid;
		host_resp.data  <= merge_data;
		if (reset) begin
			for (int a = 0; a < NUM_APPS; a++) begin
				app_req[a].valid <= 1'b0;
			end
			host_resp.valid <= 1'b0;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the shell testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_aos_shell -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
out=$(./obj_dir/Vtb_aos_shell)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
printf '%s\n' "$out" | grep -q "All tests passed" || exit 1
exit 0

/* sim/tb_aos_shell.sv */
// Testbench for the shell register path with host bus tasks, reference model and checks
`timescale 1ns/100ps

module tb_aos_shell;
	import shell_pkg::*;
	import softreg_pkg::*;

	localparam int NUM_APPS     = 4;
	localparam int HS_LIMIT     = 20;
	localparam int RESP_LIMIT   = 100;
	localparam int DRAIN_CYCLES = 8;

	logic                global_clk;
	logic                reset;
	logic [NUM_APPS-1:0] app_enable;
	axil_in_t            host;
	axil_out_t           host_rsp;

	// Reference model state
	logic [63:0]         model_regs [NUM_APPS][8];
	logic [NUM_APPS-1:0] model_en;
	axil_data_t          held_low;
	axil_data_t          hi_cache;

	aos_shell_top #(.NUM_APPS(NUM_APPS), .HOST_STAGES(2), .APP_STAGES(2)) dut (
		.global_clk (global_clk),
		.reset      (reset),
		.app_enable (app_enable),
		.host       (host),
		.host_rsp   (host_rsp)
	);

	always #4 global_clk = ~global_clk;

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic fail_stop();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic timeout_stop(input string what);
		$display("Timed out waiting for the %s handshake", what);
		fail_stop();
	endtask

	// App index in byte address bits 7:6, register in 5:3, half in bit 2
	function automatic logic [31:0] reg_addr(input int app, input int ofs, input bit half);
		return (32'(app) << 6) | (32'(ofs) << 3) | (32'(half) << 2);
	endfunction

	function automatic logic [63:0] model_word(input int app, input int ofs);
		if (!model_en[app])
			return '1;
		if (ofs == 0)
			return {APP_SIGNATURE, 32'(app)};
		return model_regs[app][ofs];
	endfunction

	// ----------------------------------------
	// Host bus
	// ----------------------------------------
	task automatic host_write(input logic [31:0] addr, input axil_data_t data);
		int cnt;
		@(negedge global_clk);
		host.awvalid = 1'b1;
		host.wvalid  = 1'b1;
		host.awaddr  = addr;
		host.wdata   = data;
		cnt = 0;
		#1;
		while (!(host_rsp.awready && host_rsp.wready)) begin
			if (cnt == HS_LIMIT)
				timeout_stop("write address and data");
			@(negedge global_clk);
			#1;
			cnt++;
		end
		@(negedge global_clk);
		host.awvalid = 1'b0;
		host.wvalid  = 1'b0;
		host.bready  = 1'b1;
		cnt = 0;
		while (!host_rsp.bvalid) begin
			if (cnt == HS_LIMIT)
				timeout_stop("write response");
			@(negedge global_clk);
			cnt++;
		end
		check_resp("bresp", AXIL_OKAY, host_rsp.bresp);
		@(negedge global_clk);
		host.bready = 1'b0;
	endtask

	task automatic host_read(input logic [31:0] addr, output axil_data_t data);
		int cnt;
		@(negedge global_clk);
		host.arvalid = 1'b1;
		host.araddr  = addr;
		cnt = 0;
		#1;
		while (!host_rsp.arready) begin
			if (cnt == HS_LIMIT)
				timeout_stop("read address");
			@(negedge global_clk);
			#1;
			cnt++;
		end
		@(negedge global_clk);
		host.arvalid = 1'b0;
		host.rready  = 1'b1;
		cnt = 0;
		while (!host_rsp.rvalid) begin
			if (cnt == RESP_LIMIT)
				timeout_stop("read data");
			@(negedge global_clk);
			cnt++;
		end
		check_resp("rresp", AXIL_OKAY, host_rsp.rresp);
		data = host_rsp.rdata;
		@(negedge global_clk);
		host.rready = 1'b0;
	endtask

	// Bus access plus the matching model update
	task automatic bus_write(input int app, input int ofs, input bit half, input axil_data_t data);
		host_write(reg_addr(app, ofs, half), data);
		if (!half)
			held_low = data;
		else if (model_en[app] && ofs != 0)
			model_regs[app][ofs] = {data, held_low};
	endtask

	task automatic bus_read(input int app, input int ofs, input bit half);
		logic [63:0] full;
		axil_data_t  exp;
		axil_data_t  act;
		if (!half) begin
			full     = model_word(app, ofs);
			exp      = full[31:0];
			hi_cache = full[63:32];
		end else begin
			exp = hi_cache;
		end
		host_read(reg_addr(app, ofs, half), act);
		check_data("rdata", exp, act);
	endtask

	task automatic write64(input int app, input int ofs, input logic [63:0] data);
		bus_write(app, ofs, 1'b0, data[31:0]);
		bus_write(app, ofs, 1'b1, data[63:32]);
	endtask

	task automatic read64(input int app, input int ofs);
		bus_read(app, ofs, 1'b0);
		bus_read(app, ofs, 1'b1);
	endtask

	// Let posted writes reach the router before the mask moves
	task automatic set_enable(input logic [NUM_APPS-1:0] mask);
		repeat (DRAIN_CYCLES) @(negedge global_clk);
		app_enable = mask;
		model_en   = mask;
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int op;
		void'($urandom(28734));
		global_clk = 1'b0;
		reset      = 1'b1;
		app_enable = '1;
		model_en   = '1;
		host       = '0;
		host.wstrb = '1;
		for (int a = 0; a < NUM_APPS; a++)
			for (int r = 0; r < 8; r++)
				model_regs[a][r] = '0;
		repeat (3) @(posedge global_clk);
		@(negedge global_clk);
		reset = 1'b0;

		// Idle handshake state and register contents out of reset
		@(negedge global_clk);
		check_flag("bvalid", 1'b0, host_rsp.bvalid);
		check_flag("rvalid", 1'b0, host_rsp.rvalid);
		check_flag("awready", 1'b1, host_rsp.awready);
		check_flag("wready", 1'b1, host_rsp.wready);
		check_flag("arready", 1'b1, host_rsp.arready);
		for (int a = 0; a < NUM_APPS; a++)
			for (int r = 0; r < 8; r++)
				read64(a, r);

		// Signature register ignores writes
		for (int a = 0; a < NUM_APPS; a++) begin
			write64(a, 0, {$urandom, $urandom});
			read64(a, 0);
		end

		// Disabled app reads all ones and drops writes
		write64(1, 2, 64'h0123_4567_89ab_cdef);
		set_enable(4'b1101);
		read64(1, 2);
		write64(1, 2, 64'hfeed_face_dead_beef);
		set_enable('1);
		read64(1, 2);

		// Lone low half and the stale high cache
		write64(2, 3, {$urandom, $urandom});
		bus_write(2, 3, 1'b0, $urandom);
		read64(2, 3);
		bus_read(2, 3, 1'b0);
		write64(2, 3, {$urandom, $urandom});
		bus_read(2, 3, 1'b1);

		for (int i = 0; i < 300; i++) begin
			op = $urandom_range(0, 9);
			case (op)
				0: set_enable(NUM_APPS'($urandom));
				1, 2, 3, 4: write64($urandom_range(0, NUM_APPS-1), $urandom_range(0, 7),
					{$urandom, $urandom});
				5, 6, 7: read64($urandom_range(0, NUM_APPS-1), $urandom_range(0, 7));
				8: bus_write($urandom_range(0, NUM_APPS-1), $urandom_range(0, 7), 1'b0, $urandom);
				default: bus_read($urandom_range(0, NUM_APPS-1), $urandom_range(0, 7), 1'b1);
			endcase
		end

		// Final sweep with everything enabled
		set_enable('1);
		for (int a = 0; a < NUM_APPS; a++)
			for (int r = 0; r < 8; r++)
				read64(a, r);

		$display("All tests passed");
		$finish;
	end

endmodule
